// File: fc_pkg.sv
// fc_pkg
// shared widths, constants and stage structs for the int8 dot-product engine.
// every stage hands a valid strobe plus one of these structs to the next.
package fc_pkg;

  ////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////
  localparam int OPERAND_W   = 8;    // feature / weight
  localparam int PRODUCT_W   = 16;   // signed 8x8 product
  localparam int ACC_W       = 28;   // partial sum
  localparam int BIAS_W      = 16;
  localparam int LEN_W       = 11;   // vector length 1..1024
  localparam int ACT_W       = 8;
  localparam int QUANT_SHIFT = 6;
  localparam int ACT_MAX     = 127;
  localparam int CLA_GROUP   = 4;    // bits per lookahead group
  localparam int MULT_STAGES = 5;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_t;

  ////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic signed [OPERAND_W-1:0] feat;
    logic signed [OPERAND_W-1:0] weight;
    logic        [BIAS_W-1:0]    bias;
    logic                        first;
    logic                        last;
  } mac_op_t;

  typedef struct packed {
    logic signed [PRODUCT_W-1:0] prod;
    logic        [BIAS_W-1:0]    bias;
    logic                        first;
    logic                        last;
  } product_t;

  typedef struct packed {
    logic [ACC_W-1:0]  sum;
    logic [BIAS_W-1:0] bias;
  } acc_sum_t;

  typedef struct packed {
    logic [ACT_W-1:0] act;   // requantized activation
    logic [ACC_W-1:0] acc;   // sum before bias
  } fc_result_t;

endpackage

// File: cla_adder.sv
// cla_adder
// carry-lookahead adder built from 4-bit groups.
// sub high computes b - a by inverting a and forcing the carry in.
`timescale 1ns/1ps

module cla_adder import fc_pkg::*; #(
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             sub,
  output logic [WIDTH-1:0] sum
);

  localparam int NGRP = WIDTH / CLA_GROUP;

  logic [WIDTH-1:0] a_eff;
  logic [WIDTH-1:0] p;
  logic [WIDTH-1:0] g;
  logic [NGRP:0]    gc;    // carry into each group

  assign a_eff = sub ? ~a : a;
  assign p     = a_eff ^ b;
  assign g     = a_eff & b;
  assign gc[0] = sub;      // +1 completes the two's complement

  for (genvar i = 0; i < NGRP; i++) begin : g_grp
    logic [CLA_GROUP-1:0] s_grp;
    logic                 gp;
    logic                 gg;
    logic                 c;

    assign gp = &p[i*CLA_GROUP +: CLA_GROUP];

    always_comb begin
      gg = 1'b0;
      c  = gc[i];
      for (int k = 0; k < CLA_GROUP; k++) begin
        gg       = g[i*CLA_GROUP+k] | (p[i*CLA_GROUP+k] & gg);
        s_grp[k] = p[i*CLA_GROUP+k] ^ c;
        c        = g[i*CLA_GROUP+k] | (p[i*CLA_GROUP+k] & c);
      end
    end

    assign gc[i+1] = gg | (gp & gc[i]);   // group carry lookahead
    assign sum[i*CLA_GROUP +: CLA_GROUP] = s_grp;
  end

  initial begin
    assert (WIDTH % CLA_GROUP == 0)
      else $error("cla_adder width %0d is not a multiple of %0d", WIDTH, CLA_GROUP);
  end

endmodule

// File: vector_sequencer.sv
// vector_sequencer
// opens a vector on start, then registers each element into a mac op
// tagged first/last and carrying the vector's bias
`timescale 1ns/1ps

module vector_sequencer import fc_pkg::*; (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 start,
  input  logic [LEN_W-1:0]     vec_len,
  input  logic [BIAS_W-1:0]    bias,
  input  logic                 elem_valid,
  input  logic [OPERAND_W-1:0] feat,
  input  logic [OPERAND_W-1:0] weight,
  output logic                 op_valid,
  output mac_op_t              op
);

  seq_state_t       state;
  logic [LEN_W-1:0] remain;      // elements still expected
  logic [BIAS_W-1:0] bias_q;
  logic             first_pend;  // next element opens the sum
  logic             accept;
  logic             is_last;

  assign accept  = (state == SEQ_RUN) && elem_valid;
  assign is_last = (remain == LEN_W'(1));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= SEQ_IDLE;
      remain     <= '0;
      first_pend <= 1'b0;
      op_valid   <= 1'b0;
    end else begin
      op_valid <= accept;
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            state      <= SEQ_RUN;
            remain     <= vec_len;
            first_pend <= 1'b1;
          end
        end
        SEQ_RUN: begin
          if (elem_valid) begin
            remain     <= remain - 1'b1;
            first_pend <= 1'b0;
            if (is_last) state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // payload path
  always_ff @(posedge clk) begin
    if (state == SEQ_IDLE && start) bias_q <= bias;
    if (accept) begin
      op.feat   <= feat;
      op.weight <= weight;
      op.bias   <= bias_q;
      op.first  <= first_pend;
      op.last   <= is_last;
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rstn) !(start && elem_valid))
    else $error("start and elem_valid seen in the same cycle");

endmodule

// File: pe_multiplier.sv
// pe_multiplier
// five-stage signed 8x8 shift-and-add multiplier.
// works on magnitudes, sign is applied in the last stage
`timescale 1ns/1ps

module pe_multiplier import fc_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     op_valid,
  input  mac_op_t  op,
  output logic     prod_valid,
  output product_t prod
);

  // tags that ride alongside the arithmetic
  typedef struct packed {
    logic              sign;
    logic [BIAS_W-1:0] bias;
    logic              first;
    logic              last;
  } side_t;

  logic [MULT_STAGES-2:0] vld;   // stages 1..4
  side_t                  side_q [MULT_STAGES-1];

  logic [OPERAND_W-1:0] a_mag, b_mag;
  logic [OPERAND_W-1:0] pp_q [OPERAND_W];   // partial products
  logic [9:0]           s2_q [4];           // pairs
  logic [11:0]          s3_q [2];           // pairs of pairs
  logic [PRODUCT_W-1:0] mag_q;              // full magnitude
  logic [PRODUCT_W-1:0] signed_prod;

  ////////////////////////////////////////////////////////////
  // stage 1 magnitudes and partial products
  ////////////////////////////////////////////////////////////
  assign a_mag = op.feat[OPERAND_W-1]   ? OPERAND_W'(-op.feat)   : op.feat;
  assign b_mag = op.weight[OPERAND_W-1] ? OPERAND_W'(-op.weight) : op.weight;

  always_ff @(posedge clk) begin
    for (int i = 0; i < OPERAND_W; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : '0;
    end
    side_q[0].sign  <= op.feat[OPERAND_W-1] ^ op.weight[OPERAND_W-1];
    side_q[0].bias  <= op.bias;
    side_q[0].first <= op.first;
    side_q[0].last  <= op.last;
    for (int s = 1; s < MULT_STAGES-1; s++) begin
      side_q[s] <= side_q[s-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // stages 2..4 adder tree
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      s2_q[k] <= 10'(pp_q[2*k]) + {pp_q[2*k+1], 1'b0};
    end
    for (int m = 0; m < 2; m++) begin
      s3_q[m] <= 12'(s2_q[2*m]) + {s2_q[2*m+1], 2'b00};
    end
    mag_q <= PRODUCT_W'(s3_q[0]) + {s3_q[1], 4'b0000};
  end

  // stage 5 sign, 0 - mag when negative
  cla_adder #(.WIDTH(PRODUCT_W)) u_neg (
    .a   (mag_q),
    .b   ('0),
    .sub (side_q[MULT_STAGES-2].sign),
    .sum (signed_prod)
  );

  always_ff @(posedge clk) begin
    prod.prod  <= signed_prod;
    prod.bias  <= side_q[MULT_STAGES-2].bias;
    prod.first <= side_q[MULT_STAGES-2].first;
    prod.last  <= side_q[MULT_STAGES-2].last;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld        <= '0;
      prod_valid <= 1'b0;
    end else begin
      vld        <= {vld[MULT_STAGES-3:0], op_valid};
      prod_valid <= vld[MULT_STAGES-2];
    end
  end

  // largest magnitude is 128*128
  a_mag_range: assert property (@(posedge clk) disable iff (!rstn)
    vld[MULT_STAGES-2] |-> mag_q <= PRODUCT_W'(16384))
    else $error("multiplier magnitude out of range: %h", mag_q);

endmodule

// File: mac_accumulator.sv
// mac_accumulator
// running sum of products per vector; first restarts it from zero,
// last hands the finished sum and its bias to the quantizer
`timescale 1ns/1ps

module mac_accumulator import fc_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     prod_valid,
  input  product_t prod,
  output logic     sum_valid,
  output acc_sum_t sum
);

  logic [ACC_W-1:0]  acc_q;
  logic [ACC_W-1:0]  prod_ext;
  logic [ACC_W-1:0]  acc_base;
  logic [ACC_W-1:0]  acc_next;
  logic [BIAS_W-1:0] bias_q;

  ////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////
  assign prod_ext = {{(ACC_W-PRODUCT_W){prod.prod[PRODUCT_W-1]}}, prod.prod};
  assign acc_base = prod.first ? '0 : acc_q;   // new vector restarts

  cla_adder #(.WIDTH(ACC_W)) u_acc_add (
    .a   (prod_ext),
    .b   (acc_base),
    .sub (1'b0),
    .sum (acc_next)
  );

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc_q <= acc_next;
    end
    if (prod_valid && prod.last) begin
      bias_q <= prod.bias;   // bias of the vector just closed
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid && prod.last;
    end
  end

  // held until the next product lands, the quantizer samples in time
  assign sum.sum  = acc_q;
  assign sum.bias = bias_q;

endmodule

// File: activation_quantizer.sv
// activation_quantizer
// bias add, relu and saturating requantization to a 7-bit activation:
// negative -> 0, else (x >> 6) clamped at 127
`timescale 1ns/1ps

module activation_quantizer import fc_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       sum_valid,
  input  acc_sum_t   sum,
  output logic       out_valid,
  output fc_result_t out_data
);

  logic [ACC_W-1:0] bias_ext;
  logic [ACC_W-1:0] biased;
  logic [ACC_W-1:0] shifted;
  logic             is_neg;
  logic             is_sat;
  logic [ACT_W-1:0] act;

  assign bias_ext = {{(ACC_W-BIAS_W){sum.bias[BIAS_W-1]}}, sum.bias};

  cla_adder #(.WIDTH(ACC_W)) u_bias_add (
    .a   (bias_ext),
    .b   (sum.sum),
    .sub (1'b0),
    .sum (biased)
  );

  ////////////////////////////////////////////////////////////
  // relu + clamp
  ////////////////////////////////////////////////////////////
  assign is_neg  = biased[ACC_W-1];
  assign shifted = biased >> QUANT_SHIFT;            // only used when positive
  assign is_sat  = shifted > ACC_W'(ACT_MAX);

  always_comb begin
    if (is_neg) act = '0;
    else if (is_sat) act = ACT_W'(ACT_MAX);
    else act = shifted[ACT_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      out_data.act <= act;
      out_data.acc <= sum.sum;   // pre-bias sum for inspection
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  a_act_range: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> out_data.act <= ACT_W'(ACT_MAX))
    else $error("activation above saturation: %h", out_data.act);

endmodule

// File: fc_mac_top.sv
// fc_mac_top
// int8 dot-product engine: sequencer -> multiplier pipeline ->
// accumulator -> activation quantizer, 8 cycles from last element to result
`timescale 1ns/1ps

module fc_mac_top import fc_pkg::*; (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 start,
  input  logic [LEN_W-1:0]     vec_len,
  input  logic [BIAS_W-1:0]    bias,
  input  logic                 elem_valid,
  input  logic [OPERAND_W-1:0] feat,
  input  logic [OPERAND_W-1:0] weight,
  output logic                 out_valid,
  output fc_result_t           out_data
);

  logic     op_valid;
  mac_op_t  op;
  logic     prod_valid;
  product_t prod;
  logic     sum_valid;
  acc_sum_t sum;

  // producer
  vector_sequencer u_seq (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .vec_len    (vec_len),
    .bias       (bias),
    .elem_valid (elem_valid),
    .feat       (feat),
    .weight     (weight),
    .op_valid   (op_valid),
    .op         (op)
  );

  pe_multiplier u_mult (
    .clk        (clk),
    .rstn       (rstn),
    .op_valid   (op_valid),
    .op         (op),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  // consumer side
  mac_accumulator u_acc (
    .clk        (clk),
    .rstn       (rstn),
    .prod_valid (prod_valid),
    .prod       (prod),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  activation_quantizer u_quant (
    .clk       (clk),
    .rstn      (rstn),
    .sum_valid (sum_valid),
    .sum       (sum),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

// File: tb_fc_mac.sv
// tb_fc_mac
// self-checking testbench for the int8 dot-product engine.
// a scoreboard queue holds the expected acc/act per vector,
// concurrent assertions compare results and check the 8-cycle latency
`timescale 1ns/1ps

module tb_fc_mac import fc_pkg::*; ();

  logic                 clk;
  logic                 rstn;
  logic                 start;
  logic [LEN_W-1:0]     vec_len;
  logic [BIAS_W-1:0]    bias;
  logic                 elem_valid;
  logic [OPERAND_W-1:0] feat;
  logic [OPERAND_W-1:0] weight;
  logic                 out_valid;
  fc_result_t           out_data;

  logic       drv_last;    // marks the element that closes a vector
  logic       idle_chk;    // window where no result may appear
  fc_result_t exp_q [$];   // scoreboard
  fc_result_t exp_head;
  logic       exp_avail;
  int         seed;
  int         err_val;
  int         err_proto;
  int         err_tmo;

  fc_mac_top UUT (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .vec_len    (vec_len),
    .bias       (bias),
    .elem_valid (elem_valid),
    .feat       (feat),
    .weight     (weight),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;   // 4 ns period

  ////////////////////////////////////////////////////////////
  // scoreboard head, refreshed away from the sampling edge
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rstn && out_valid && exp_q.size() > 0) exp_q.delete(0);
  end

  always @(negedge clk) begin
    exp_avail = (exp_q.size() > 0);
    if (exp_avail) exp_head = exp_q[0];
  end

  a_acc: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && exp_avail |-> out_data.acc == exp_head.acc)
    else begin
      err_val++;
      $display("ERR out_data.acc got %h expected %h", $sampled(out_data.acc),
               $sampled(exp_head.acc));
    end

  a_act: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && exp_avail |-> out_data.act == exp_head.act)
    else begin
      err_val++;
      $display("ERR out_data.act got %h expected %h", $sampled(out_data.act),
               $sampled(exp_head.act));
    end

  a_unexp: assert property (@(posedge clk) disable iff (!rstn) out_valid |-> exp_avail)
    else begin
      err_proto++;
      $display("out_valid seen while no result was expected");
    end

  a_latency: assert property (@(posedge clk) disable iff (!rstn)
    elem_valid && drv_last |-> ##8 out_valid)
    else begin
      err_proto++;
      $display("no out_valid 8 cycles after the last element of a vector");
    end

  a_stray: assert property (@(posedge clk) disable iff (!rstn)
    out_valid |-> $past(elem_valid && drv_last, 8))
    else begin
      err_proto++;
      $display("out_valid without a last element 8 cycles earlier");
    end

  a_idle: assert property (@(posedge clk) disable iff (!rstn) idle_chk |-> !out_valid)
    else begin
      err_proto++;
      $display("out_valid rose during the idle window after reset");
    end

  ////////////////////////////////////////////////////////////
  // reference model and stimulus
  ////////////////////////////////////////////////////////////
  // relu, shift by 6, clamp at 127
  function automatic logic [ACT_W-1:0] quantize(input longint acc, input longint b);
    longint biased;
    longint shifted;
    biased = acc + b;
    if (biased < 0) return '0;
    shifted = biased >>> QUANT_SHIFT;
    if (shifted > ACT_MAX) return ACT_W'(ACT_MAX);
    return ACT_W'(shifted);
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // leaves the last element driven so the next start can follow at once
  task automatic run_vector(input int len, input logic [BIAS_W-1:0] b, input bit rand_ops,
                            input logic [OPERAND_W-1:0] f_fix,
                            input logic [OPERAND_W-1:0] w_fix);
    longint     acc;
    fc_result_t res;
    int         i;
    acc = 0;
    step();
    elem_valid = 1'b0;
    drv_last   = 1'b0;
    start      = 1'b1;
    vec_len    = LEN_W'(len);
    bias       = b;
    for (i = 0; i < len; i++) begin
      step();
      start      = 1'b0;
      feat       = rand_ops ? OPERAND_W'($random(seed)) : f_fix;
      weight     = rand_ops ? OPERAND_W'($random(seed)) : w_fix;
      elem_valid = 1'b1;
      drv_last   = (i == len - 1);
      acc += longint'($signed(feat)) * longint'($signed(weight));
    end
    res.acc = ACC_W'(acc);
    res.act = quantize(acc, longint'($signed(b)));
    exp_q.push_back(res);
  endtask

  task automatic release_inputs();
    step();
    start      = 1'b0;
    elem_valid = 1'b0;
    drv_last   = 1'b0;
  endtask

  task automatic wait_result(input int max_cycles);
    int n;
    n = 0;
    while (!out_valid && n < max_cycles) begin
      step();
      n++;
    end
    if (!out_valid) begin
      err_tmo++;
      $display("timeout: no out_valid within %0d cycles", max_cycles);
    end
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      step();
      n++;
    end
    if (exp_q.size() != 0) begin
      err_tmo++;
      $display("timeout: %0d results still pending after %0d cycles", exp_q.size(),
               max_cycles);
    end
  endtask

  initial begin
    int v;
    seed       = 32'h3c26;
    rstn       = 1'b0;
    start      = 1'b0;
    vec_len    = '0;
    bias       = '0;
    elem_valid = 1'b0;
    feat       = '0;
    weight     = '0;
    drv_last   = 1'b0;
    idle_chk   = 1'b0;
    exp_avail  = 1'b0;
    exp_head   = '0;
    err_val    = 0;
    err_proto  = 0;
    err_tmo    = 0;
    repeat (8) @(posedge clk);
    #1 rstn = 1'b1;

    idle_chk = 1'b1;   // quiet after reset
    repeat (20) step();
    idle_chk = 1'b0;

    run_vector(1, BIAS_W'(40), 1'b1, '0, '0);   // single element
    release_inputs();
    wait_result(20);
    wait_drain(4);

    for (v = 0; v < 12; v++) begin   // back to back, random lengths
      run_vector(1 + ($unsigned($random(seed)) % 16), BIAS_W'($random(seed)), 1'b1, '0, '0);
    end
    release_inputs();
    wait_drain(60);

    run_vector(4, BIAS_W'(0), 1'b0, 8'h80, 8'h80);     // saturates to 127
    run_vector(8, BIAS_W'(100), 1'b0, 8'h80, 8'h7f);   // large negative, act 0
    release_inputs();
    wait_drain(40);

    // stray elements while no vector is open
    for (v = 0; v < 3; v++) begin
      step();
      elem_valid = 1'b1;
      feat       = OPERAND_W'($random(seed));
      weight     = OPERAND_W'($random(seed));
    end
    release_inputs();
    repeat (12) step();
    run_vector(5, BIAS_W'($random(seed)), 1'b1, '0, '0);
    release_inputs();
    wait_drain(40);
    repeat (10) step();

    $display("errors: %0d value, %0d protocol, %0d timeout", err_val, err_proto, err_tmo);
    if (err_val == 0 && err_proto == 0 && err_tmo == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: fc_mac.f
fc_pkg.sv
cla_adder.sv
vector_sequencer.sv
pe_multiplier.sv
mac_accumulator.sv
activation_quantizer.sv
fc_mac_top.sv
tb_fc_mac.sv

// File: Bender.yml
package:
  name: fc_mac

sources:
  - fc_pkg.sv
  - cla_adder.sv
  - vector_sequencer.sv
  - pe_multiplier.sv
  - mac_accumulator.sv
  - activation_quantizer.sv
  - fc_mac_top.sv
  - target: simulation
    files:
      - tb_fc_mac.sv
